/* hw/cpu_pkg.sv */
// Pipeline widths, instruction field types and fixed constants, imported by the front-end RTL
package cpu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int PC_WD     = 32;
    localparam int INST_WD   = 32;
    localparam int OPCODE_WD = 7;

    typedef logic [PC_WD-1:0]     pc_t;
    typedef logic [INST_WD-1:0]   inst_t;
    typedef logic [OPCODE_WD-1:0] opcode_t;

    // --------------------
    // Constants
    // --------------------
    // Major opcode of JAL
    localparam opcode_t OPCODE_JAL = 7'b110_1111;

    // First fetch address after reset
    localparam pc_t RESET_PC_DEFAULT = 32'h8000_0000;

endpackage

/* hw/mem_pkg.sv */
// Instruction SRAM word and address types plus default geometry, imported by SRAM users
package mem_pkg;

    // Default word-index width, overridden by the ADDR_WD module parameter
    localparam int SRAM_ADDR_WD_DEFAULT = 10;
    localparam int SRAM_DATA_WD         = 32;

    typedef logic [SRAM_ADDR_WD_DEFAULT-1:0] sram_addr_t;
    typedef logic [SRAM_DATA_WD-1:0]         sram_data_t;

    // --------------------
    // Timing
    // --------------------
    // Cycles from an accepted request to valid read data
    localparam int SRAM_LATENCY_DEFAULT = 2;

endpackage

/* hw/ifu.sv */
// Fetch stage of the front-end top, which picks the next PC, requests it from the SRAM and hands words to decode
module ifu #(
    parameter cpu_pkg::pc_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                ds_allowin,
    input  logic                br_taken,
    input  cpu_pkg::pc_t        br_target,
    input  logic                flush,
    input  cpu_pkg::pc_t        flush_pc,
    output logic                fs_to_ds_valid,
    output cpu_pkg::pc_t        fs_pc,
    output cpu_pkg::inst_t      fs_inst,
    output logic                inst_en,
    output cpu_pkg::pc_t        inst_addr,
    input  logic                inst_ready,
    input  logic                inst_valid,
    input  mem_pkg::sram_data_t inst_rdata
);
    import cpu_pkg::*;

    logic start_q;
    logic fs_valid;
    logic pend_valid;
    pc_t  pend_pc;

    logic redirect_in;
    logic redirect_any;
    pc_t  redirect_pc;
    pc_t  seq_pc;
    pc_t  next_pc;
    logic fs_leave;
    logic fs_allowin;
    logic inst_accept;

    // --------------------
    // Next PC
    // --------------------
    // Flush beats branch and an incoming redirect beats a pending one
    assign redirect_in  = flush || br_taken;
    assign redirect_any = redirect_in || pend_valid;
    assign redirect_pc  = flush    ? flush_pc  :
                          br_taken ? br_target :
                                     pend_pc;

    assign seq_pc  = fs_pc + 32'd4;
    assign next_pc = redirect_any ? redirect_pc : seq_pc;

    // --------------------
    // Stage control
    // --------------------
    // Word is usable only if it is live and no redirect is in the way
    assign fs_to_ds_valid = fs_valid && inst_valid && !redirect_any;
    assign fs_leave       = fs_to_ds_valid && ds_allowin;

    // Stale or empty stage can always take a new request
    assign fs_allowin  = !fs_valid || redirect_any || fs_leave;
    assign inst_en     = start_q && fs_allowin;
    assign inst_addr   = next_pc;
    assign inst_accept = inst_en && inst_ready;

    // SRAM output registers hold the word until the next accept
    assign fs_inst = inst_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_q    <= 1'b0;
            fs_valid   <= 1'b0;
            pend_valid <= 1'b0;
            // One word before the first fetch so that seq_pc starts at RESET_PC
            fs_pc      <= RESET_PC - 32'd4;
        end else begin
            start_q <= start;
            if (inst_accept) begin
                fs_valid   <= 1'b1;
                pend_valid <= 1'b0;
                fs_pc      <= next_pc;
            end else begin
                if (fs_leave) begin
                    fs_valid <= 1'b0;
                end
                if (redirect_in) begin
                    // Response of the old request is dropped when it returns
                    pend_valid <= 1'b1;
                end
            end
        end
    end

    // Redirect target waits here until the SRAM can take it
    always_ff @(posedge clk) begin
        if (redirect_in && !inst_accept) begin
            pend_pc <= redirect_pc;
        end
    end

endmodule

/* hw/inst_sram.sv */
// Instruction memory: load port for program images, one-outstanding read port with fixed latency
module inst_sram #(
    parameter int LATENCY = mem_pkg::SRAM_LATENCY_DEFAULT,
    parameter int ADDR_WD = mem_pkg::SRAM_ADDR_WD_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                load_en,
    input  logic [ADDR_WD-1:0]  load_addr,
    input  mem_pkg::sram_data_t load_data,
    input  logic                inst_en,
    input  cpu_pkg::pc_t        inst_addr,
    output logic                inst_ready,
    output logic                inst_valid,
    output mem_pkg::sram_data_t inst_rdata
);
    import mem_pkg::*;

    localparam int DEPTH  = 2 ** ADDR_WD;
    localparam int CNT_WD = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    sram_data_t mem [DEPTH];

    logic [ADDR_WD-1:0] rd_index;
    logic [CNT_WD-1:0]  lat_cnt;
    logic               rd_valid;
    sram_data_t         rd_data;
    logic               accept;

    // Byte PC to word index, upper bits wrap
    assign rd_index = inst_addr[ADDR_WD+1:2];

    // Counter at zero means idle or data already valid
    assign inst_ready = (lat_cnt == '0);
    assign accept     = inst_en && inst_ready;

    assign inst_valid = rd_valid;
    assign inst_rdata = rd_data;

    // --------------------
    // Array
    // --------------------
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        // Read at accept, exposed once the latency runs out
        if (accept) begin
            rd_data <= mem[rd_index];
        end
    end

    // --------------------
    // Latency tracking
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            lat_cnt  <= '0;
            rd_valid <= 1'b0;
        end else if (accept) begin
            lat_cnt  <= CNT_WD'(LATENCY - 1);
            rd_valid <= (LATENCY == 1);
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
            if (lat_cnt == CNT_WD'(1)) begin
                rd_valid <= 1'b1;
            end
        end
    end

endmodule

/* hw/idu.sv */
// Decode stage: holds one fetched word, spots JAL and sends the jump target back to fetch
module idu (
    input  logic           clk,
    input  logic           reset,
    input  logic           fs_to_ds_valid,
    input  cpu_pkg::pc_t   fs_pc,
    input  cpu_pkg::inst_t fs_inst,
    output logic           ds_allowin,
    input  logic           flush,
    input  logic           out_ready,
    output logic           out_valid,
    output cpu_pkg::pc_t   out_pc,
    output cpu_pkg::inst_t out_inst,
    output logic           br_taken,
    output cpu_pkg::pc_t   br_target
);
    import cpu_pkg::*;

    logic    ds_valid;
    pc_t     ds_pc;
    inst_t   ds_inst;
    logic    ds_leave;
    logic    ds_load;
    opcode_t ds_opcode;
    logic    is_jal;
    pc_t     imm_j;

    // --------------------
    // Stage register
    // --------------------
    assign ds_allowin = !ds_valid || out_ready;
    assign ds_leave   = ds_valid && out_ready;
    assign ds_load    = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            // Wrong-path contents are squashed
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_load) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    assign out_valid = ds_valid;
    assign out_pc    = ds_pc;
    assign out_inst  = ds_inst;

    // --------------------
    // JAL redirect
    // --------------------
    assign ds_opcode = ds_inst[6:0];
    assign is_jal    = (ds_opcode == OPCODE_JAL);

    // J-type immediate, sign-extended, bit 0 always zero
    assign imm_j = {{11{ds_inst[31]}},
                    ds_inst[31],
                    ds_inst[19:12],
                    ds_inst[20],
                    ds_inst[30:21],
                    1'b0};

    // Pulse only in the cycle the JAL is handed on
    assign br_taken  = ds_leave && is_jal;
    assign br_target = ds_pc + imm_j;

endmodule

/* hw/frontend_top.sv */
// Front-end top: fetch, instruction SRAM and decode wired together, parameters set here
module frontend_top #(
    parameter cpu_pkg::pc_t RESET_PC = cpu_pkg::RESET_PC_DEFAULT,
    parameter int           LATENCY  = mem_pkg::SRAM_LATENCY_DEFAULT,
    parameter int           ADDR_WD  = mem_pkg::SRAM_ADDR_WD_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                load_en,
    input  logic [ADDR_WD-1:0]  load_addr,
    input  mem_pkg::sram_data_t load_data,
    input  logic                flush,
    input  cpu_pkg::pc_t        flush_pc,
    input  logic                out_ready,
    output logic                out_valid,
    output cpu_pkg::pc_t        out_pc,
    output cpu_pkg::inst_t      out_inst
);
    import cpu_pkg::*;
    import mem_pkg::*;

    // Fetch to decode
    logic  fs_to_ds_valid;
    pc_t   fs_pc;
    inst_t fs_inst;
    logic  ds_allowin;

    // Decode back to fetch
    logic  br_taken;
    pc_t   br_target;

    // Fetch to SRAM
    logic       inst_en;
    pc_t        inst_addr;
    logic       inst_ready;
    logic       inst_valid;
    sram_data_t inst_rdata;

    ifu #(
        .RESET_PC(RESET_PC)
    ) i_ifu (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .ds_allowin    (ds_allowin),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .flush         (flush),
        .flush_pc      (flush_pc),
        .fs_to_ds_valid(fs_to_ds_valid),
        .fs_pc         (fs_pc),
        .fs_inst       (fs_inst),
        .inst_en       (inst_en),
        .inst_addr     (inst_addr),
        .inst_ready    (inst_ready),
        .inst_valid    (inst_valid),
        .inst_rdata    (inst_rdata)
    );

    inst_sram #(
        .LATENCY(LATENCY),
        .ADDR_WD(ADDR_WD)
    ) i_inst_sram (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .inst_en   (inst_en),
        .inst_addr (inst_addr),
        .inst_ready(inst_ready),
        .inst_valid(inst_valid),
        .inst_rdata(inst_rdata)
    );

    idu i_idu (
        .clk           (clk),
        .reset         (reset),
        .fs_to_ds_valid(fs_to_ds_valid),
        .fs_pc         (fs_pc),
        .fs_inst       (fs_inst),
        .ds_allowin    (ds_allowin),
        .flush         (flush),
        .out_ready     (out_ready),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .br_taken      (br_taken),
        .br_target     (br_target)
    );

endmodule

/* test/tb_frontend.sv */
// Directed testbench for the fetch/decode front end, built and run through the Makefile
module tb_frontend;
    import cpu_pkg::*;
    import mem_pkg::*;

    localparam int  WORDS    = 1024;
    localparam pc_t START_PC = RESET_PC_DEFAULT;

    logic       clk;
    logic       reset;
    logic       start;
    logic       load_en;
    logic [9:0] load_addr;
    sram_data_t load_data;
    logic       flush;
    pc_t        flush_pc;
    logic       out_ready;
    logic       out_valid;
    pc_t        out_pc;
    inst_t      out_inst;

    // Program image and jump table for the reference model
    inst_t prog [WORDS];
    logic  is_jump [WORDS];
    pc_t   jump_off [WORDS];

    pc_t   got_pc [$];
    inst_t got_inst [$];
    int    flush_idx;
    int    errors;
    int    checks;

    frontend_top #(.RESET_PC(START_PC), .LATENCY(2), .ADDR_WD(10)) i_frontend_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // --------------------
    // Program building
    // --------------------
    // ADDI-format filler, every word differs by its index
    task automatic clear_program();
        logic [9:0] w;
        for (int i = 0; i < WORDS; i++) begin
            w           = i[9:0];
            prog[i]     = {2'b00, w, 13'h0000, 7'h13};
            is_jump[i]  = 1'b0;
            jump_off[i] = 32'd4;
        end
    endtask

    // JAL with rd = x1, offset counted in words
    task automatic place_jal(input int idx, input int words);
        logic [20:0] off;
        off           = 21'(words * 4);
        prog[idx]     = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b110_1111};
        is_jump[idx]  = 1'b1;
        jump_off[idx] = pc_t'(words * 4);
    endtask

    task automatic place_jumps();
        place_jal(3, 8);
        place_jal(14, -10);
        place_jal(6, 16);
        place_jal(22, 2);
        place_jal(27, 100);
    endtask

    function automatic pc_t step_pc(input pc_t pc);
        if (is_jump[pc[11:2]]) begin
            return pc + jump_off[pc[11:2]];
        end
        return pc + 32'd4;
    endfunction

    task automatic load_and_start();
        @(posedge clk);
        #1;
        start = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            load_en   = 1'b1;
            load_addr = i[9:0];
            load_data = prog[i];
            @(posedge clk);
            #1;
        end
        load_en = 1'b0;
        reset   = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        start = 1'b1;
    endtask

    // --------------------
    // Stream collection
    // --------------------
    task automatic compare_model(input string name, input pc_t fpc);
        pc_t pc;
        int  split;
        split = (flush_idx < 0) ? got_pc.size() : flush_idx;
        pc    = START_PC;
        for (int k = 0; k < got_pc.size(); k++) begin
            if (k == split) begin
                pc = fpc;
            end
            check_value({name, " pc"}, pc, got_pc[k]);
            check_value({name, " inst"}, prog[pc[11:2]], got_inst[k]);
            pc = step_pc(pc);
        end
    endtask

    task automatic run_stream(input string name, input int n, input int stall_pct,
                              input int flush_at, input pc_t fpc, input bit stall_flush);
        int    cycles;
        int    limit;
        bit    flushed;
        bit    holding;
        pc_t   held_pc;
        inst_t held_inst;
        got_pc.delete();
        got_inst.delete();
        flush_idx = -1;
        cycles    = 0;
        limit     = 40 * n + 100;
        flushed   = 1'b0;
        holding   = 1'b0;
        held_pc   = '0;
        held_inst = '0;
        load_and_start();
        while (got_pc.size() < n && cycles < limit) begin
            out_ready = ($urandom_range(99) >= stall_pct);
            flush     = 1'b0;
            if (flush_at >= 0 && !flushed && got_pc.size() >= flush_at &&
                (!stall_flush || out_valid)) begin
                flush    = 1'b1;
                flush_pc = fpc;
                flushed  = 1'b1;
                if (stall_flush) begin
                    out_ready = 1'b0;
                end
            end
            // Sample mid-cycle, an accept happens at the next rising edge
            @(negedge clk);
            if (holding) begin
                check_value({name, " hold valid"}, 32'd1, {31'd0, out_valid});
                check_value({name, " hold pc"}, held_pc, out_pc);
                check_value({name, " hold inst"}, held_inst, out_inst);
            end
            holding   = out_valid && !out_ready && !flush;
            held_pc   = out_pc;
            held_inst = out_inst;
            if (out_valid && out_ready) begin
                got_pc.push_back(out_pc);
                got_inst.push_back(out_inst);
            end
            if (flush) begin
                flush_idx = got_pc.size();
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        flush = 1'b0;
        if (got_pc.size() < n) begin
            errors++;
            $display("%s: only %0d of %0d instructions within %0d cycles",
                     name, got_pc.size(), n, limit);
        end
        compare_model(name, fpc);
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic sequential_fetch();
        clear_program();
        run_stream("sequential", 20, 0, -1, '0, 1'b0);
        if (got_pc.size() > 0) begin
            check_value("sequential first pc", START_PC, got_pc[0]);
        end
    endtask

    task automatic back_pressure();
        clear_program();
        run_stream("backpressure", 30, 45, -1, '0, 1'b0);
    endtask

    task automatic jal_redirect();
        clear_program();
        place_jumps();
        run_stream("jal", 24, 0, -1, '0, 1'b0);
    endtask

    task automatic flush_mid_stream();
        clear_program();
        run_stream("flush", 20, 0, 8, 32'h8000_0400, 1'b0);
    endtask

    task automatic mixed_traffic();
        clear_program();
        place_jumps();
        run_stream("mixed", 60, 30, 25, 32'h8000_0020, 1'b1);
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        flush_idx = -1;
        reset     = 1'b1;
        start     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        flush     = 1'b0;
        flush_pc  = '0;
        out_ready = 1'b0;
        void'($urandom(32'hc6dd));
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        sequential_fetch();
        back_pressure();
        jal_redirect();
        flush_mid_stream();
        mixed_traffic();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/cpu_pkg.sv
hw/mem_pkg.sv
hw/ifu.sv
hw/inst_sram.sv
hw/idu.sv
hw/frontend_top.sv
test/tb_frontend.sv

/* Makefile */
BUILD := build
LOG   := sim.log

.PHONY: all lint clean

all: $(BUILD)/Vtb_frontend
	./$(BUILD)/Vtb_frontend > $(LOG) 2>&1 || echo "Testbench failed" >> $(LOG)
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi

$(BUILD)/Vtb_frontend: filelist.f $(wildcard hw/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --top-module tb_frontend -Mdir $(BUILD) -o Vtb_frontend -f filelist.f

lint:
	verilator --lint-only --timing --top-module tb_frontend -f filelist.f

clean:
	rm -rf $(BUILD) $(LOG)
